// ==== dv/tb_state_cache.sv ====
`timescale 1ns/1ns
`include "state_cache_params.svh"

module tb_state_cache;

    localparam int MAX_ROWS = 128;

    typedef enum logic [1:0] {OP_LOOKUP, OP_DELETE, OP_IDLE, OP_CLEAR} op_e;

    // One stimulus row with the values the model expects for it
    typedef struct packed {
        op_e                 op;
        logic [`KEY_WID-1:0] arg;
        logic                exp_valid;
        logic                exp_new;
        logic [`ID_WID-1:0]  exp_id;
        logic [`ID_WID:0]    exp_fill;
        logic [31:0]         exp_req;
        logic [31:0]         exp_existing;
        logic [31:0]         exp_new_cnt;
        logic [31:0]         exp_not_tracked;
    } row_t;

    // Ack still owed by the DUT
    typedef struct packed {
        int                 due;
        logic               valid;
        logic               is_new;
        logic [`ID_WID-1:0] id;
        logic [`ID_WID:0]   fill;
    } pend_t;

    logic                 clk;
    logic                 htable_srst;
    logic                 i_lookup_req;
    logic [`KEY_WID-1:0]  i_lookup_key;
    logic                 i_delete_req;
    logic [`ID_WID-1:0]   i_delete_id;
    logic                 i_cnt_clear;
    logic                 o_init_done;
    logic                 o_lookup_ack;
    logic                 o_lookup_valid;
    logic                 o_lookup_new;
    logic [`ID_WID-1:0]   o_lookup_id;
    logic [`ID_WID:0]     o_fill;
    logic [`CNT_WID-1:0]  o_cnt_req;
    logic [`CNT_WID-1:0]  o_cnt_existing;
    logic [`CNT_WID-1:0]  o_cnt_new;
    logic [`CNT_WID-1:0]  o_cnt_not_tracked;

    row_t  rows [MAX_ROWS];
    int    n_rows = 0;
    pend_t pending [$];
    int    step_idx = 0;
    int    cycle_cnt = 0;
    int    cycle_limit = 1000;
    logic [15:0] lfsr_state = 16'd53;

    // Reference model of slots, free list, key store and counters
    bit                  m_valid [32];
    logic [`KEY_WID-1:0] m_key [32];
    logic [`ID_WID-1:0]  m_id [32];
    bit                  m_alloc [16];
    logic [`KEY_WID-1:0] m_idkey [16];
    logic [`ID_WID-1:0]  m_free [$];
    int                  m_fill = 0;
    int                  m_req = 0;
    int                  m_existing = 0;
    int                  m_new = 0;
    int                  m_not_tracked = 0;

    state_cache_top u_dut (
        .clk               (clk),
        .htable_srst       (htable_srst),
        .i_lookup_req      (i_lookup_req),
        .i_lookup_key      (i_lookup_key),
        .i_delete_req      (i_delete_req),
        .i_delete_id       (i_delete_id),
        .i_cnt_clear       (i_cnt_clear),
        .o_init_done       (o_init_done),
        .o_lookup_ack      (o_lookup_ack),
        .o_lookup_valid    (o_lookup_valid),
        .o_lookup_new      (o_lookup_new),
        .o_lookup_id       (o_lookup_id),
        .o_fill            (o_fill),
        .o_cnt_req         (o_cnt_req),
        .o_cnt_existing    (o_cnt_existing),
        .o_cnt_new         (o_cnt_new),
        .o_cnt_not_tracked (o_cnt_not_tracked)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Model helpers
    // ------------------------------------------------------------------------
    // Slot index is the XOR of three 5-bit key fields with key bit 15 on bit 0
    function automatic logic [4:0] fold_key(input logic [15:0] k);
        logic [4:0] s;
        s    = k[4:0] ^ k[9:5] ^ k[14:10];
        s[0] = s[0] ^ k[15];
        return s;
    endfunction

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [15:0] random_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v          = {v[14:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    task automatic append_row(input row_t r);
        rows[n_rows] = r;
        n_rows++;
    endtask

    task automatic lookup_row(input logic [15:0] key);
        row_t       r;
        logic [4:0] s;
        r     = '0;
        r.op  = OP_LOOKUP;
        r.arg = key;
        s     = fold_key(key);
        m_req++;
        if (m_valid[s] && (m_key[s] == key)) begin
            r.exp_valid = 1'b1;
            r.exp_id    = m_id[s];
            m_existing++;
        end else if (!m_valid[s] && (m_free.size() != 0)) begin
            r.exp_valid = 1'b1;
            r.exp_new   = 1'b1;
            r.exp_id    = m_free.pop_front();
            m_valid[s]  = 1'b1;
            m_key[s]    = key;
            m_id[s]     = r.exp_id;
            m_alloc[r.exp_id] = 1'b1;
            m_idkey[r.exp_id] = key;
            m_fill++;
            m_new++;
        end else begin
            m_not_tracked++;
        end
        r.exp_fill = 5'(m_fill);
        append_row(r);
    endtask

    task automatic delete_row(input logic [3:0] id);
        row_t r;
        r     = '0;
        r.op  = OP_DELETE;
        r.arg = 16'(id);
        // Unallocated IDs leave everything as it is
        if (m_alloc[id]) begin
            m_valid[fold_key(m_idkey[id])] = 1'b0;
            m_free.push_back(id);
            m_alloc[id] = 1'b0;
            m_fill--;
        end
        r.exp_fill = 5'(m_fill);
        append_row(r);
    endtask

    task automatic idle_rows(input int n);
        row_t r;
        r    = '0;
        r.op = OP_IDLE;
        for (int i = 0; i < n; i++) begin
            append_row(r);
        end
    endtask

    // Totals seen just before the clear
    task automatic clear_row();
        row_t r;
        r                 = '0;
        r.op              = OP_CLEAR;
        r.exp_req         = 32'(m_req);
        r.exp_existing    = 32'(m_existing);
        r.exp_new_cnt     = 32'(m_new);
        r.exp_not_tracked = 32'(m_not_tracked);
        m_req         = 0;
        m_existing    = 0;
        m_new         = 0;
        m_not_tracked = 0;
        append_row(r);
    endtask

    task automatic build_table();
        logic [15:0] pool [8];
        for (int i = 0; i < 16; i++) begin
            m_free.push_back(4'(i));
        end
        // Spaced distinct keys and one repeat
        for (int k = 1; k <= 3; k++) begin
            lookup_row(16'(k));
            idle_rows(2);
        end
        lookup_row(16'h0001);
        idle_rows(2);
        // Back-to-back pairs of one key and of one slot with two keys
        lookup_row(16'h0004);
        lookup_row(16'h0004);
        idle_rows(2);
        lookup_row(16'h0005);
        lookup_row(16'h8004);
        idle_rows(2);
        lookup_row(16'h0421);
        idle_rows(2);
        // Remaining IDs used up before one more new key
        for (int k = 6; k <= 16; k++) begin
            lookup_row(16'(k));
        end
        lookup_row(16'h0011);
        idle_rows(1);
        delete_row(4'd2);
        lookup_row(16'h0003);
        idle_rows(1);
        delete_row(4'd7);
        delete_row(4'd7);
        lookup_row(16'h0008);
        idle_rows(1);
        clear_row();
        // Open some room for the random keys
        delete_row(4'd0);
        delete_row(4'd1);
        delete_row(4'd4);
        delete_row(4'd9);
        for (int i = 0; i < 8; i++) begin
            pool[i] = random_bits(16);
        end
        for (int i = 0; i < 24; i++) begin
            lookup_row(pool[random_bits(3)]);
            if (random_bits(1) != 0) begin
                idle_rows(1);
            end
        end
        clear_row();
    endtask

    // ------------------------------------------------------------------------
    // Checking
    // ------------------------------------------------------------------------
    task automatic stop_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic report_failure(input string msg);
        $display("Failure at %0t ns: %s", $time, msg);
        stop_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] act,
                               input logic [31:0] exp);
        assert (act === exp) else begin
            $display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_counters(input logic [31:0] req, input logic [31:0] ex,
                                  input logic [31:0] nw, input logic [31:0] nt);
        check_value("o_cnt_req", o_cnt_req, req);
        check_value("o_cnt_existing", o_cnt_existing, ex);
        check_value("o_cnt_new", o_cnt_new, nw);
        check_value("o_cnt_not_tracked", o_cnt_not_tracked, nt);
    endtask

    // Ack must come on its due step and on no other
    task automatic check_outputs();
        logic  exp_ack;
        pend_t p;
        exp_ack = (pending.size() != 0) && (pending[0].due == step_idx);
        check_value("o_lookup_ack", 32'(o_lookup_ack), 32'(exp_ack));
        if (exp_ack) begin
            p = pending.pop_front();
            check_value("o_lookup_valid", 32'(o_lookup_valid), 32'(p.valid));
            check_value("o_lookup_new", 32'(o_lookup_new), 32'(p.is_new));
            if (p.valid) begin
                check_value("o_lookup_id", 32'(o_lookup_id), 32'(p.id));
            end
            check_value("o_fill", 32'(o_fill), 32'(p.fill));
        end
    endtask

    task automatic clear_inputs();
        i_lookup_req = 1'b0;
        i_delete_req = 1'b0;
        i_cnt_clear  = 1'b0;
    endtask

    // Outputs are sampled and inputs driven 1 ns after the edge
    task automatic advance_cycle();
        @(posedge clk);
        #1;
        step_idx++;
        check_outputs();
        clear_inputs();
    endtask

    task automatic drain_pipeline();
        while (pending.size() != 0) begin
            advance_cycle();
        end
        // One more cycle for the counters
        advance_cycle();
    endtask

    task automatic apply_row(input row_t r);
        pend_t p;
        case (r.op)
            OP_LOOKUP: begin
                advance_cycle();
                i_lookup_req = 1'b1;
                i_lookup_key = r.arg;
                p.due    = step_idx + 3;
                p.valid  = r.exp_valid;
                p.is_new = r.exp_new;
                p.id     = r.exp_id;
                p.fill   = r.exp_fill;
                pending.push_back(p);
            end
            OP_DELETE: begin
                drain_pipeline();
                advance_cycle();
                i_delete_req = 1'b1;
                i_delete_id  = r.arg[3:0];
                for (int k = 1; k <= 5; k++) begin
                    advance_cycle();
                    if (k == 3) begin
                        check_value("o_fill", 32'(o_fill), 32'(r.exp_fill));
                    end
                end
            end
            OP_CLEAR: begin
                drain_pipeline();
                check_counters(r.exp_req, r.exp_existing, r.exp_new_cnt, r.exp_not_tracked);
                advance_cycle();
                i_cnt_clear = 1'b1;
                advance_cycle();
                check_counters(0, 0, 0, 0);
            end
            default: begin
                advance_cycle();
            end
        endcase
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            stop_run();
        end
    end

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        int wait_cycles;
        htable_srst  = 1'b1;
        i_lookup_req = 1'b0;
        i_lookup_key = '0;
        i_delete_req = 1'b0;
        i_delete_id  = '0;
        i_cnt_clear  = 1'b0;
        build_table();
        cycle_limit = n_rows * 4 + 100;
        repeat (2) @(posedge clk);
        #1;
        htable_srst = 1'b0;
        check_value("o_init_done", 32'(o_init_done), 0);
        check_value("o_lookup_ack", 32'(o_lookup_ack), 0);
        check_value("o_fill", 32'(o_fill), 0);
        check_counters(0, 0, 0, 0);
        wait_cycles = 0;
        while (!o_init_done) begin
            advance_cycle();
            wait_cycles++;
            assert (wait_cycles <= 20) else begin
                report_failure("o_init_done did not rise within 20 cycles of reset");
            end
        end
        for (int i = 0; i < n_rows; i++) begin
            apply_row(rows[i]);
        end
        drain_pipeline();
        check_counters(32'(m_req), 32'(m_existing), 32'(m_new), 32'(m_not_tracked));
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+hw
hw/state_cache_pkg.sv
hw/state_cache_intf.sv
hw/state_table.sv
hw/state_id_manager.sv
hw/lookup_pipeline.sv
hw/cache_counters.sv
hw/state_cache_top.sv
dv/tb_state_cache.sv

// ==== hw/cache_counters.sv ====
`timescale 1ns/1ns
`include "state_cache_params.svh"

module cache_counters (
    input  logic                            clk,
    input  logic                            htable_srst,
    input  logic                            i_cnt_clear,
    input  logic                            i_result_valid,
    input  state_cache_pkg::lookup_result_e i_result,
    output logic [`CNT_WID-1:0]             o_cnt_req,
    output logic [`CNT_WID-1:0]             o_cnt_existing,
    output logic [`CNT_WID-1:0]             o_cnt_new,
    output logic [`CNT_WID-1:0]             o_cnt_not_tracked
);

    // One request count plus one outcome count per result
    always_ff @(posedge clk) begin
        if (htable_srst || i_cnt_clear) begin
            o_cnt_req         <= '0;
            o_cnt_existing    <= '0;
            o_cnt_new         <= '0;
            o_cnt_not_tracked <= '0;
        end else if (i_result_valid) begin
            o_cnt_req <= o_cnt_req + `CNT_WID'(1);
            case (i_result)
                state_cache_pkg::RES_EXISTING: begin
                    o_cnt_existing <= o_cnt_existing + `CNT_WID'(1);
                end
                state_cache_pkg::RES_NEW: begin
                    o_cnt_new <= o_cnt_new + `CNT_WID'(1);
                end
                state_cache_pkg::RES_NOT_TRACKED: begin
                    o_cnt_not_tracked <= o_cnt_not_tracked + `CNT_WID'(1);
                end
                default: begin
                    o_cnt_not_tracked <= o_cnt_not_tracked;
                end
            endcase
        end
    end

endmodule

// ==== hw/lookup_pipeline.sv ====
`timescale 1ns/1ns
`include "state_cache_params.svh"

module lookup_pipeline (
    input  logic                            clk,
    input  logic                            htable_srst,
    input  logic                            i_lookup_req,
    input  logic [`KEY_WID-1:0]             i_lookup_key,
    table_port_if.reader                    o_port,
    id_alloc_if.consumer                    o_alloc,
    output logic                            o_busy,
    output logic                            o_lookup_ack,
    output logic                            o_lookup_valid,
    output logic                            o_lookup_new,
    output logic [`ID_WID-1:0]              o_lookup_id,
    output state_cache_pkg::lookup_result_e o_result
);

    // Stage 1, read issue
    logic                     s1_valid;
    logic [`KEY_WID-1:0]      s1_key;
    logic [`SLOT_IDX_WID-1:0] s1_idx;

    // Stage 2, decision
    logic                     s2_valid;
    logic [`KEY_WID-1:0]      s2_key;
    logic [`SLOT_IDX_WID-1:0] s2_idx;

    // Last insert, for a read that raced it
    logic                          fwd_valid;
    logic [`SLOT_IDX_WID-1:0]      fwd_idx;
    state_cache_pkg::table_entry_t fwd_entry;

    state_cache_pkg::table_entry_t   cur_entry;
    state_cache_pkg::lookup_result_e dec_result;
    logic [`ID_WID-1:0]              dec_id;
    logic                            do_insert;

    assign s1_idx = state_cache_pkg::slot_of(s1_key);
    assign o_busy = s1_valid || s2_valid;

    assign o_port.rd_en  = s1_valid;
    assign o_port.rd_idx = s1_idx;

    // ---------------------------------------------------------------------------
    // Hit / insert / not-tracked decision
    // ---------------------------------------------------------------------------
    // Previous cycle wrote this slot after our read was taken
    assign cur_entry = (fwd_valid && (fwd_idx == s2_idx)) ? fwd_entry : o_port.rd_entry;

    always_comb begin
        dec_result = state_cache_pkg::RES_NOT_TRACKED;
        dec_id     = cur_entry.id;
        if (cur_entry.valid && (cur_entry.key == s2_key)) begin
            dec_result = state_cache_pkg::RES_EXISTING;
        end else if (!cur_entry.valid && o_alloc.avail) begin
            dec_result = state_cache_pkg::RES_NEW;
            dec_id     = o_alloc.free_id;
        end
    end

    assign do_insert = s2_valid && (dec_result == state_cache_pkg::RES_NEW);

    assign o_alloc.take     = do_insert;
    assign o_alloc.take_key = s2_key;

    assign o_port.wr_en          = do_insert;
    assign o_port.wr_idx         = s2_idx;
    assign o_port.wr_entry.valid = 1'b1;
    assign o_port.wr_entry.key   = s2_key;
    assign o_port.wr_entry.id    = o_alloc.free_id;

    // ---------------------------------------------------------------------------
    // Pipeline registers
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            s1_valid       <= 1'b0;
            s2_valid       <= 1'b0;
            fwd_valid      <= 1'b0;
            o_lookup_ack   <= 1'b0;
            o_lookup_valid <= 1'b0;
            o_lookup_new   <= 1'b0;
        end else begin
            s1_valid       <= i_lookup_req;
            s2_valid       <= s1_valid;
            fwd_valid      <= do_insert;
            o_lookup_ack   <= s2_valid;
            o_lookup_valid <= s2_valid && (dec_result != state_cache_pkg::RES_NOT_TRACKED);
            o_lookup_new   <= do_insert;
        end
    end

    always_ff @(posedge clk) begin
        s1_key      <= i_lookup_key;
        s2_key      <= s1_key;
        s2_idx      <= s1_idx;
        fwd_idx     <= o_port.wr_idx;
        fwd_entry   <= o_port.wr_entry;
        o_lookup_id <= dec_id;
        o_result    <= dec_result;
    end

endmodule

// ==== hw/state_cache_intf.sv ====
`timescale 1ns/1ns
`include "state_cache_params.svh"

// ---------------------------------------------------------------------------
// Table access port, lookup side reads and inserts
// ---------------------------------------------------------------------------
interface table_port_if;
    logic                          rd_en;
    logic [`SLOT_IDX_WID-1:0]      rd_idx;
    state_cache_pkg::table_entry_t rd_entry;
    logic                          wr_en;
    logic [`SLOT_IDX_WID-1:0]      wr_idx;
    state_cache_pkg::table_entry_t wr_entry;

    modport reader (
        output rd_en, rd_idx, wr_en, wr_idx, wr_entry,
        input  rd_entry
    );

    modport owner (
        input  rd_en, rd_idx, wr_en, wr_idx, wr_entry,
        output rd_entry
    );
endinterface

// ---------------------------------------------------------------------------
// Free ID handout, head of the free list plus key capture
// ---------------------------------------------------------------------------
interface id_alloc_if;
    logic                avail;
    logic [`ID_WID-1:0]  free_id;
    logic                take;
    logic [`KEY_WID-1:0] take_key;

    modport provider (
        output avail, free_id,
        input  take, take_key
    );

    modport consumer (
        input  avail, free_id,
        output take, take_key
    );
endinterface

// ==== hw/state_cache_params.svh ====
`ifndef STATE_CACHE_PARAMS_SVH
`define STATE_CACHE_PARAMS_SVH

// Flow key width
`define KEY_WID 16

// State ID width, 16 IDs in the free list
`define ID_WID 4

// Table index width, 32 direct-mapped slots
`define SLOT_IDX_WID 5

// Outcome counter width
`define CNT_WID 32

`endif

// ==== hw/state_cache_pkg.sv ====
`include "state_cache_params.svh"

package state_cache_pkg;

    // One table slot
    typedef struct packed {
        logic                valid;
        logic [`KEY_WID-1:0] key;
        logic [`ID_WID-1:0]  id;
    } table_entry_t;

    typedef enum logic [1:0] {
        RES_EXISTING,
        RES_NEW,
        RES_NOT_TRACKED
    } lookup_result_e;

    typedef enum logic [1:0] {
        ST_INIT,
        ST_IDLE,
        ST_DEL_READ,
        ST_DEL_CLEAR
    } id_mgr_state_e;

    // Fold the key into a slot index, top key bit lands on index bit 0
    function automatic logic [`SLOT_IDX_WID-1:0] slot_of(input logic [`KEY_WID-1:0] key);
        logic [`SLOT_IDX_WID-1:0] idx;
        idx    = key[4:0] ^ key[9:5] ^ key[14:10];
        idx[0] = idx[0] ^ key[15];
        return idx;
    endfunction

endpackage

// ==== hw/state_cache_top.sv ====
`timescale 1ns/1ns
`include "state_cache_params.svh"

module state_cache_top (
    input  logic                 clk,
    input  logic                 htable_srst,
    input  logic                 i_lookup_req,
    input  logic [`KEY_WID-1:0]  i_lookup_key,
    input  logic                 i_delete_req,
    input  logic [`ID_WID-1:0]   i_delete_id,
    input  logic                 i_cnt_clear,
    output logic                 o_init_done,
    output logic                 o_lookup_ack,
    output logic                 o_lookup_valid,
    output logic                 o_lookup_new,
    output logic [`ID_WID-1:0]   o_lookup_id,
    output logic [`ID_WID:0]     o_fill,
    output logic [`CNT_WID-1:0]  o_cnt_req,
    output logic [`CNT_WID-1:0]  o_cnt_existing,
    output logic [`CNT_WID-1:0]  o_cnt_new,
    output logic [`CNT_WID-1:0]  o_cnt_not_tracked
);

    logic                            clr_en;
    logic [`SLOT_IDX_WID-1:0]        clr_idx;
    logic                            busy;
    state_cache_pkg::lookup_result_e result;

    table_port_if u_table_if ();
    id_alloc_if   u_alloc_if ();

    // ---------------------------------------------------------------------------
    // Slot storage and ID bookkeeping
    // ---------------------------------------------------------------------------
    state_table u_table (
        .clk         (clk),
        .htable_srst (htable_srst),
        .i_port      (u_table_if),
        .i_clr_en    (clr_en),
        .i_clr_idx   (clr_idx)
    );

    state_id_manager u_id_mgr (
        .clk          (clk),
        .htable_srst  (htable_srst),
        .i_alloc      (u_alloc_if),
        .i_delete_req (i_delete_req),
        .i_delete_id  (i_delete_id),
        .i_busy       (busy),
        .o_clr_en     (clr_en),
        .o_clr_idx    (clr_idx),
        .o_init_done  (o_init_done),
        .o_fill       (o_fill)
    );

    // ---------------------------------------------------------------------------
    // Lookup path and statistics
    // ---------------------------------------------------------------------------
    lookup_pipeline u_lookup (
        .clk            (clk),
        .htable_srst    (htable_srst),
        .i_lookup_req   (i_lookup_req),
        .i_lookup_key   (i_lookup_key),
        .o_port         (u_table_if),
        .o_alloc        (u_alloc_if),
        .o_busy         (busy),
        .o_lookup_ack   (o_lookup_ack),
        .o_lookup_valid (o_lookup_valid),
        .o_lookup_new   (o_lookup_new),
        .o_lookup_id    (o_lookup_id),
        .o_result       (result)
    );

    // Every ack counts as one result
    cache_counters u_counters (
        .clk               (clk),
        .htable_srst       (htable_srst),
        .i_cnt_clear       (i_cnt_clear),
        .i_result_valid    (o_lookup_ack),
        .i_result          (result),
        .o_cnt_req         (o_cnt_req),
        .o_cnt_existing    (o_cnt_existing),
        .o_cnt_new         (o_cnt_new),
        .o_cnt_not_tracked (o_cnt_not_tracked)
    );

endmodule

// ==== hw/state_id_manager.sv ====
`timescale 1ns/1ns
`include "state_cache_params.svh"

module state_id_manager (
    input  logic                     clk,
    input  logic                     htable_srst,
    id_alloc_if.provider             i_alloc,
    input  logic                     i_delete_req,
    input  logic [`ID_WID-1:0]       i_delete_id,
    input  logic                     i_busy,
    output logic                     o_clr_en,
    output logic [`SLOT_IDX_WID-1:0] o_clr_idx,
    output logic                     o_init_done,
    output logic [`ID_WID:0]         o_fill
);

    localparam int NUM_IDS = 2**`ID_WID;

    state_cache_pkg::id_mgr_state_e state;

    logic [`ID_WID-1:0]  free_mem [NUM_IDS];
    logic [`ID_WID-1:0]  head_ptr;
    logic [`ID_WID-1:0]  tail_ptr;
    logic [`ID_WID:0]    free_cnt;
    logic                push;
    logic [`ID_WID-1:0]  push_id;
    logic                pop;

    logic [`KEY_WID-1:0] key_mem [NUM_IDS];
    logic [NUM_IDS-1:0]  allocated;
    logic [`ID_WID-1:0]  del_id;
    logic [`KEY_WID-1:0] del_key;

    // ---------------------------------------------------------------------------
    // Control FSM
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            state <= state_cache_pkg::ST_INIT;
        end else begin
            case (state)
                state_cache_pkg::ST_INIT: begin
                    if (tail_ptr == '1) begin
                        state <= state_cache_pkg::ST_IDLE;
                    end
                end
                state_cache_pkg::ST_IDLE: begin
                    if (i_delete_req) begin
                        state <= state_cache_pkg::ST_DEL_READ;
                    end
                end
                // Unallocated IDs drop out here
                state_cache_pkg::ST_DEL_READ: begin
                    if (allocated[del_id]) begin
                        state <= state_cache_pkg::ST_DEL_CLEAR;
                    end else begin
                        state <= state_cache_pkg::ST_IDLE;
                    end
                end
                default: begin
                    state <= state_cache_pkg::ST_IDLE;
                end
            endcase
        end
    end

    assign o_init_done = (state != state_cache_pkg::ST_INIT);
    assign o_clr_en    = (state == state_cache_pkg::ST_DEL_CLEAR);
    assign o_clr_idx   = state_cache_pkg::slot_of(del_key);

    // During init the tail pointer doubles as the ID being pushed
    assign push    = (state == state_cache_pkg::ST_INIT) || o_clr_en;
    assign push_id = o_clr_en ? del_id : tail_ptr;
    assign pop     = i_alloc.take;

    assign i_alloc.avail   = o_init_done && (free_cnt != '0);
    assign i_alloc.free_id = free_mem[head_ptr];

    // ---------------------------------------------------------------------------
    // Free list pointers, allocation flags and fill count
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            head_ptr  <= '0;
            tail_ptr  <= '0;
            free_cnt  <= '0;
            allocated <= '0;
            o_fill    <= '0;
        end else begin
            if (push) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (pop) begin
                head_ptr                     <= head_ptr + 1'b1;
                allocated[i_alloc.free_id]   <= 1'b1;
            end
            if (o_clr_en) begin
                allocated[del_id] <= 1'b0;
            end
            case ({push, pop})
                2'b10:   free_cnt <= free_cnt + 1'b1;
                2'b01:   free_cnt <= free_cnt - 1'b1;
                default: free_cnt <= free_cnt;
            endcase
            case ({pop, o_clr_en})
                2'b10:   o_fill <= o_fill + 1'b1;
                2'b01:   o_fill <= o_fill - 1'b1;
                default: o_fill <= o_fill;
            endcase
        end
    end

    // Free list and key store contents
    always_ff @(posedge clk) begin
        if (push) begin
            free_mem[tail_ptr] <= push_id;
        end
        if (pop) begin
            key_mem[i_alloc.free_id] <= i_alloc.take_key;
        end
    end

    // Delete context
    always_ff @(posedge clk) begin
        if ((state == state_cache_pkg::ST_IDLE) && i_delete_req) begin
            del_id <= i_delete_id;
        end
        if (state == state_cache_pkg::ST_DEL_READ) begin
            del_key <= key_mem[del_id];
        end
    end

    // A delete racing a lookup could clear a slot the lookup is inserting
    a_delete_when_idle: assert property (
        @(posedge clk) disable iff (htable_srst) i_delete_req |-> !i_busy
    );

    a_take_needs_avail: assert property (
        @(posedge clk) disable iff (htable_srst) i_alloc.take |-> i_alloc.avail
    );

endmodule

// ==== hw/state_table.sv ====
`timescale 1ns/1ns
`include "state_cache_params.svh"

module state_table (
    input  logic                     clk,
    input  logic                     htable_srst,
    table_port_if.owner              i_port,
    input  logic                     i_clr_en,
    input  logic [`SLOT_IDX_WID-1:0] i_clr_idx
);

    localparam int NUM_SLOTS = 2**`SLOT_IDX_WID;

    state_cache_pkg::table_entry_t slot_mem [NUM_SLOTS];
    logic [NUM_SLOTS-1:0]          slot_valid;

    // ---------------------------------------------------------------------------
    // Valid bits, insert beats clear
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            slot_valid <= '0;
        end else if (i_port.wr_en) begin
            slot_valid[i_port.wr_idx] <= i_port.wr_entry.valid;
        end else if (i_clr_en) begin
            slot_valid[i_clr_idx] <= 1'b0;
        end
    end

    // Key and ID storage
    always_ff @(posedge clk) begin
        if (i_port.wr_en) begin
            slot_mem[i_port.wr_idx] <= i_port.wr_entry;
        end
    end

    // Registered read, old data on a same-edge write
    always_ff @(posedge clk) begin
        if (i_port.rd_en) begin
            i_port.rd_entry.valid <= slot_valid[i_port.rd_idx];
            i_port.rd_entry.key   <= slot_mem[i_port.rd_idx].key;
            i_port.rd_entry.id    <= slot_mem[i_port.rd_idx].id;
        end
    end

    // Deletes only run with the lookup pipe empty, so no write collision
    a_no_write_collision: assert property (
        @(posedge clk) disable iff (htable_srst) !(i_clr_en && i_port.wr_en)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the state cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_state_cache \
    -f files.f -o tb_state_cache > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_state_cache > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi
exit 0
